/* vlog.f */
common/icache_pkg.sv
icache/icache_tlb.sv
icache/icache_way.sv
icache/icache_hit_select.sv
icache/icache_ctrl.sv
src/icache_top.sv
verification/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - common/icache_pkg.sv
  - icache/icache_tlb.sv
  - icache/icache_way.sv
  - icache/icache_hit_select.sv
  - icache/icache_ctrl.sv
  - src/icache_top.sv
  - target: test
    files:
      - verification/icache_tb.sv

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

  localparam int clk_period  = 20;
  localparam int num_random  = 200;
  localparam int fetch_limit = 48;   // Cycles allowed from handshake to dp_valid
  localparam int watchdog_ns = ((num_random + 16) * (fetch_limit + 8) + 200) * clk_period;

  logic       clk;
  logic       rst;
  logic       read_valid;
  logic       read_ready;
  logic       dp_valid;
  logic       dp_ready;
  logic       tlb_wr_en;
  logic       bus_grant;
  logic       bus_busy;
  logic       mem_req;
  logic       mem_ready;
  addr_t      va;
  fetch_rsp_t dp_rsp;
  tlb_wr_t    tlb_wr;
  mem_addr_t  mem_addr;
  word_t      mem_rdata;

  logic [31:0] rng_state;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          test_start_errors;
  logic        req_prev;
  logic        grant_prev;

  // Reference model
  logic tm_valid [tlb_entries];
  vpn_t tm_vpn   [tlb_entries];
  ppn_t tm_ppn   [tlb_entries];
  logic cm_valid [num_ways][num_sets];
  tag_t cm_tag   [num_ways][num_sets];
  way_t cm_lru   [num_sets];   // Next victim per set

  icache_top u_icache_top (.*);

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state ^ (rng_state << 13);
    x = x ^ (x >> 17);
    rng_state = x ^ (x << 5);
    return rng_state;
  endfunction

  function automatic word_t mem_word(input mem_addr_t a);
    return {a, 4'h9, a} ^ 32'h6d2e17c5;
  endfunction

  // Lowest valid matching entry gives the page
  function automatic logic translate(input addr_t v, output addr_t pa);
    logic hit;
    hit = 1'b0;
    pa  = '0;
    for (int i = 0; i < tlb_entries; i++) begin
      if (!hit && tm_valid[i] && tm_vpn[i] == v[15:10]) begin
        hit = 1'b1;
        pa  = {tm_ppn[i], v[9:0]};
      end
    end
    return hit;
  endfunction

  function automatic int held_way(input addr_t pa);
    for (int w = 0; w < num_ways; w++) begin
      if (cm_valid[w][pa[4:3]] && cm_tag[w][pa[4:3]] == pa[15:5]) return w;
    end
    return -1;   // Line absent
  endfunction

  task automatic note_error(input string msg);
    $display("ERROR at %t: %s", $time, msg);
    errors++;
  endtask

  task automatic drive_edge();
    @(posedge clk);
    #2;
    bus_grant = next_rand() % 4 != 0;
    bus_busy  = next_rand() % 4 == 0;
    mem_ready = next_rand() % 3 != 0;
    mem_rdata = mem_word(mem_addr);
  endtask

  // Bus rule is watched at every sample point
  task automatic sample();
    @(negedge clk);
    if (mem_req && !req_prev && !grant_prev) begin
      note_error("mem_req rose without a free bus grant in the cycle before");
    end
    req_prev   = mem_req;
    grant_prev = bus_grant && !bus_busy;
  endtask

  task automatic load_tlb(input tlb_idx_t e, input logic [31:0] r);
    drive_edge();
    tlb_wr_en   = 1'b1;
    tlb_wr      = '{entry: e, valid: r[1:0] != 2'b00, vpn: vpn_t'(r[4:2]), ppn: ppn_t'(r[7:5])};
    tm_valid[e] = tlb_wr.valid;
    tm_vpn[e]   = tlb_wr.vpn;
    tm_ppn[e]   = tlb_wr.ppn;
    sample();
    drive_edge();
    tlb_wr_en = 1'b0;
    sample();
  endtask

  task automatic do_fetch(input addr_t v, output logic filled);
    addr_t      pa;
    logic       mapped;
    int         way;
    int         cyc;
    int         beats;
    fetch_rsp_t first;
    mapped = translate(v, pa);
    way    = mapped ? held_way(pa) : -1;
    filled = 1'b0;
    beats  = 0;
    cyc    = 0;
    drive_edge();
    read_valid = 1'b1;
    va         = v;
    dp_ready   = 1'b0;
    sample();
    if (!read_ready) note_error("read_ready low while the DUT should be idle");
    do begin
      drive_edge();
      read_valid = 1'b0;
      sample();
      cyc++;
      if (mem_req) begin
        filled = 1'b1;
        if (mem_ready) begin
          if (mem_addr !== {pa[15:3], beats[0]}) begin
            note_error($sformatf("beat %0d at mem_addr %h, expected %h", beats, mem_addr,
                                 {pa[15:3], beats[0]}));
          end
          beats++;
        end
      end
    end while (!dp_valid && cyc < fetch_limit);
    if (!dp_valid) begin
      $display("Fetch of va %h got no response within %0d cycles", v, fetch_limit);
      errors++;
      return;
    end
    first = dp_rsp;
    if (!mapped) begin
      if (first.fault !== 1'b1 || first.instr !== '0 || cyc != 2 || filled) begin
        note_error($sformatf("unmapped va %h: fault %b instr %h after %0d cycles, bus %b",
                             v, first.fault, first.instr, cyc, filled));
      end
    end else begin
      if (first.fault !== 1'b0 || first.instr !== mem_word(pa[15:2])) begin
        note_error($sformatf("va %h: fault %b instr %h, expected instr %h", v, first.fault,
                             first.instr, mem_word(pa[15:2])));
      end
      if (way >= 0) begin
        if (cyc != 2 || filled) note_error($sformatf("hit on va %h took %0d cycles", v, cyc));
      end else begin
        if (beats != 2) note_error($sformatf("miss on va %h took %0d beats", v, beats));
        way = cm_lru[pa[4:3]];
        cm_valid[way][pa[4:3]] = 1'b1;
        cm_tag[way][pa[4:3]]   = pa[15:5];
      end
      cm_lru[pa[4:3]] = ~way_t'(way);
    end
    repeat (next_rand() % 4) begin
      drive_edge();
      sample();
      if (!dp_valid || dp_rsp !== first || read_ready) begin
        note_error("response moved or read_ready rose while dp_ready was low");
      end
    end
    drive_edge();
    dp_ready = 1'b1;
    sample();
    if (!dp_valid || dp_rsp !== first) note_error("response dropped before dp_ready");
    drive_edge();
    dp_ready = 1'b0;
    sample();
    if (dp_valid || !read_ready) note_error("DUT did not return to idle after the response");
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  initial begin
    logic  filled;
    addr_t pa_a;
    addr_t pa_b;
    addr_t kept;
    addr_t lost;
    $timeformat(-9, 0, " ns", 0);
    rng_state  = 32'h630f82ab;
    clk        = 1'b0;
    rst        = 1'b1;
    read_valid = 1'b0;
    va         = '0;
    dp_ready   = 1'b0;
    tlb_wr_en  = 1'b0;
    tlb_wr     = '0;
    bus_grant  = 1'b0;
    bus_busy   = 1'b0;
    mem_ready  = 1'b0;
    mem_rdata  = '0;
    errors            = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    test_start_errors = 0;
    req_prev   = 1'b0;
    grant_prev = 1'b0;
    tm_valid = '{default: 1'b0};
    cm_valid = '{default: '{default: 1'b0}};
    cm_lru   = '{default: '0};
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    sample();
    if (!read_ready || dp_valid || mem_req) note_error("wrong handshake outputs after reset");

    do_fetch(16'h1234, filled);   // TLB still empty
    load_tlb(0, 32'h0000_0131);   // vpn 4 to ppn 1
    do_fetch(16'h1644, filled);
    finish_test("tlb_miss");

    do_fetch(16'h1000, filled);
    if (!filled) note_error("first fetch of a line caused no fill");
    do_fetch(16'h1004, filled);
    if (filled) note_error("fetch of the other word of a filled line caused a fill");
    finish_test("fill_then_hit");

    // Three lines of page 4 in set 2
    do_fetch(16'h1010, filled);
    do_fetch(16'h1030, filled);
    do_fetch(16'h1050, filled);
    void'(translate(16'h1010, pa_a));
    void'(translate(16'h1030, pa_b));
    kept = held_way(pa_a) >= 0 ? 16'h1010 : 16'h1030;
    lost = held_way(pa_a) >= 0 ? 16'h1030 : 16'h1010;
    do_fetch(kept, filled);
    if (filled) note_error("refetch of the kept line caused a fill");
    do_fetch(lost, filled);
    if (!filled) note_error("refetch of the evicted line caused no fill");
    finish_test("lru_replace");

    for (int e = 0; e < tlb_entries; e++) begin
      load_tlb(tlb_idx_t'(e), next_rand());
    end
    for (int n = 0; n < num_random; n++) begin
      logic [31:0] r;
      r = next_rand();
      if (n % 16 == 15) load_tlb(tlb_idx_t'(r[9:8]), next_rand());
      do_fetch({3'b000, r[2:0], 4'b0000, r[6:3], 2'b00}, filled);
    end
    finish_test("random_fetch");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Run timed out after %0d ns without finishing the tests", watchdog_ns);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* src/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       read_valid,
  input  addr_t      va,
  output logic       read_ready,
  output logic       dp_valid,
  input  logic       dp_ready,
  output fetch_rsp_t dp_rsp,
  input  logic       tlb_wr_en,
  input  tlb_wr_t    tlb_wr,
  input  logic       bus_grant,
  input  logic       bus_busy,
  output logic       mem_req,
  output mem_addr_t  mem_addr,
  input  logic       mem_ready,
  input  word_t      mem_rdata
);

  pa_u                  pa;
  pa_u                  phys_pa;
  logic                 tlb_hit;
  ppn_t                 tlb_ppn;
  logic [num_ways-1:0]  way_hit;
  word_t [num_ways-1:0] way_data;
  logic                 cache_hit;
  word_t                hit_data;
  way_t                 victim;
  fill_wr_t             fill_wr;
  logic [num_ways-1:0]  fill_way_en;
  logic                 fill_done;
  logic                 lru_touch;

  // TLB page swapped in, offset passes straight through
  assign phys_pa.page_view = '{ppn: tlb_ppn, offset: pa.page_view.offset};

  icache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .read_valid  (read_valid),
    .va          (va),
    .read_ready  (read_ready),
    .dp_valid    (dp_valid),
    .dp_ready    (dp_ready),
    .dp_rsp      (dp_rsp),
    .pa          (pa),
    .tlb_hit     (tlb_hit),
    .ppn         (tlb_ppn),
    .cache_hit   (cache_hit),
    .hit_data    (hit_data),
    .victim      (victim),
    .fill_wr     (fill_wr),
    .fill_way_en (fill_way_en),
    .fill_done   (fill_done),
    .lru_touch   (lru_touch),
    .bus_grant   (bus_grant),
    .bus_busy    (bus_busy),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata)
  );

  icache_tlb u_tlb (
    .clk       (clk),
    .rst       (rst),
    .tlb_wr_en (tlb_wr_en),
    .tlb_wr    (tlb_wr),
    .vpn       (pa.page_view.ppn),   // Still the virtual page here
    .tlb_hit   (tlb_hit),
    .ppn       (tlb_ppn)
  );

  for (genvar g = 0; g < num_ways; g++) begin : g_way
    icache_way u_way (
      .clk      (clk),
      .rst      (rst),
      .pa       (phys_pa),
      .fill_wr  (fill_wr),
      .fill_en  (fill_way_en[g]),
      .way_hit  (way_hit[g]),
      .way_data (way_data[g])
    );
  end

  icache_hit_select u_hit_select (
    .clk       (clk),
    .rst       (rst),
    .index     (pa.cache_view.index),
    .way_hit   (way_hit),
    .way_data  (way_data),
    .lru_touch (lru_touch),
    .fill_done (fill_done),
    .cache_hit (cache_hit),
    .hit_data  (hit_data),
    .victim    (victim)
  );

endmodule

`default_nettype wire

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_valid,
  input  addr_t               va,
  output logic                read_ready,
  output logic                dp_valid,
  input  logic                dp_ready,
  output fetch_rsp_t          dp_rsp,
  output pa_u                 pa,
  input  logic                tlb_hit,
  input  ppn_t                ppn,
  input  logic                cache_hit,
  input  word_t               hit_data,
  input  way_t                victim,
  output fill_wr_t            fill_wr,
  output logic [num_ways-1:0] fill_way_en,
  output logic                fill_done,
  output logic                lru_touch,
  input  logic                bus_grant,
  input  logic                bus_busy,
  output logic                mem_req,
  output mem_addr_t           mem_addr,
  input  logic                mem_ready,
  input  word_t               mem_rdata
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  pa_u         addr_q;      // Page field still holds the vpn
  ppn_t        line_ppn_q;
  word_sel_t   beat_q;
  fetch_rsp_t  rsp_q;
  pa_u         fill_pa;
  logic        beat_take;
  logic        last_beat;

  // Physical line under fill
  assign fill_pa.page_view = '{ppn: line_ppn_q, offset: addr_q.page_view.offset};

  assign read_ready = state_q == idle;
  assign dp_valid   = state_q == respond;
  assign dp_rsp     = rsp_q;
  assign pa         = addr_q;
  assign mem_req    = state_q == fill;
  assign mem_addr   = {fill_pa.cache_view.tag, fill_pa.cache_view.index, beat_q};
  assign lru_touch  = (state_q == lookup) && tlb_hit && cache_hit;

  assign beat_take = mem_req && mem_ready;
  assign last_beat = beat_q == word_sel_t'(words_per_line - 1);
  assign fill_done = beat_take && last_beat;

  assign fill_wr = '{
    index:    fill_pa.cache_view.index,
    word_sel: beat_q,
    data:     mem_rdata,
    tag:      fill_pa.cache_view.tag
  };

  always_comb begin
    for (int i = 0; i < num_ways; i++) begin
      fill_way_en[i] = beat_take && (victim == way_t'(i));
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle:     if (read_valid) state_d = lookup;
      lookup: begin
        if (!tlb_hit || cache_hit) begin
          state_d = respond;
        end else begin
          state_d = bus_wait;
        end
      end
      bus_wait: if (bus_grant && !bus_busy) state_d = fill;
      fill:     if (fill_done) state_d = lookup;   // Retry, now hits
      respond:  if (dp_ready) state_d = idle;
      default:  state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= idle;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == bus_wait) begin
        beat_q <= '0;
      end else if (beat_take) begin
        beat_q <= word_sel_t'(beat_q + 1'b1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read_ready && read_valid) begin
      addr_q.page_view <= va;
    end
    if (state_q == lookup) begin
      line_ppn_q  <= ppn;
      rsp_q.fault <= !tlb_hit;
      rsp_q.instr <= tlb_hit ? hit_data : '0;   // Zero on fault
    end
  end

endmodule

`default_nettype wire

/* icache/icache_hit_select.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_hit_select import icache_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  index_t                     index,
  input  logic [num_ways-1:0]        way_hit,
  input  word_t [num_ways-1:0]       way_data,
  input  logic                       lru_touch,
  input  logic                       fill_done,
  output logic                       cache_hit,
  output word_t                      hit_data,
  output way_t                       victim
);

  way_t lru_q [num_sets];   // Way not used last
  way_t hit_way;

  assign cache_hit = |way_hit;
  assign victim    = lru_q[index];

  always_comb begin
    hit_way  = '0;
    hit_data = '0;
    for (int i = 0; i < num_ways; i++) begin
      if (way_hit[i]) begin
        hit_way  = way_t'(i);
        hit_data = way_data[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < num_sets; s++) begin
        lru_q[s] <= '0;
      end
    end else if (fill_done) begin
      lru_q[index] <= ~victim;    // Fresh line is now MRU
    end else if (lru_touch) begin
      lru_q[index] <= ~hit_way;
    end
  end

endmodule

`default_nettype wire

/* icache/icache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way import icache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  pa_u      pa,
  input  fill_wr_t fill_wr,
  input  logic     fill_en,
  output logic     way_hit,
  output word_t    way_data
);

  logic [num_sets-1:0] valid_q;
  tag_t                tag_q  [num_sets];
  word_t               data_q [num_sets][words_per_line];
  index_t              rd_index;
  logic                last_word;

  assign rd_index  = pa.cache_view.index;
  assign last_word = fill_wr.word_sel == word_sel_t'(words_per_line - 1);

  // Line turns valid only once the upper word lands
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_wr.index] <= last_word;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[fill_wr.index]                     <= fill_wr.tag;
      data_q[fill_wr.index][fill_wr.word_sel] <= fill_wr.data;
    end
  end

  assign way_hit  = valid_q[rd_index] && (tag_q[rd_index] == pa.cache_view.tag);
  assign way_data = data_q[rd_index][pa.cache_view.word_sel];

endmodule

`default_nettype wire

/* icache/icache_tlb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tlb import icache_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    tlb_wr_en,
  input  tlb_wr_t tlb_wr,
  input  vpn_t    vpn,
  output logic    tlb_hit,
  output ppn_t    ppn
);

  logic [tlb_entries-1:0] valid_q;
  vpn_t                   vpn_q [tlb_entries];
  ppn_t                   ppn_q [tlb_entries];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tlb_wr_en) begin
      valid_q[tlb_wr.entry] <= tlb_wr.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (tlb_wr_en) begin
      vpn_q[tlb_wr.entry] <= tlb_wr.vpn;
      ppn_q[tlb_wr.entry] <= tlb_wr.ppn;
    end
  end

  // Scan from the top so the lowest matching entry wins
  always_comb begin
    tlb_hit = 1'b0;
    ppn     = '0;
    for (int i = tlb_entries - 1; i >= 0; i--) begin
      if (valid_q[i] && vpn_q[i] == vpn) begin
        tlb_hit = 1'b1;
        ppn     = ppn_q[i];
      end
    end
  end

endmodule

`default_nettype wire

/* common/icache_pkg.sv */
`default_nettype none

package icache_pkg;

  localparam int addr_w         = 16;
  localparam int page_off_w     = 10;
  localparam int byte_off_w     = 2;
  localparam int num_ways       = 2;
  localparam int num_sets       = 4;
  localparam int words_per_line = 2;
  localparam int tlb_entries    = 4;

  localparam int index_w    = $clog2(num_sets);
  localparam int word_sel_w = $clog2(words_per_line);
  localparam int tag_w      = addr_w - index_w - word_sel_w - byte_off_w;
  localparam int page_num_w = addr_w - page_off_w;

  typedef logic [addr_w-1:0]            addr_t;
  typedef logic [addr_w-byte_off_w-1:0] mem_addr_t;   // Word address
  typedef logic [31:0]                  word_t;
  typedef logic [page_num_w-1:0]        vpn_t;
  typedef logic [page_num_w-1:0]        ppn_t;
  typedef logic [tag_w-1:0]             tag_t;
  typedef logic [index_w-1:0]           index_t;
  typedef logic [word_sel_w-1:0]        word_sel_t;
  typedef logic [$clog2(num_ways)-1:0]  way_t;
  typedef logic [$clog2(tlb_entries)-1:0] tlb_idx_t;

  typedef struct packed {
    tag_t                  tag;
    index_t                index;
    word_sel_t             word_sel;
    logic [byte_off_w-1:0] byte_off;
  } cache_view_t;

  typedef struct packed {
    ppn_t                  ppn;
    logic [page_off_w-1:0] offset;
  } page_view_t;

  // Same 16 bits, seen by the TLB side and by the cache side
  typedef union packed {
    cache_view_t cache_view;
    page_view_t  page_view;
  } pa_u;

  typedef struct packed {
    logic  fault;
    word_t instr;
  } fetch_rsp_t;

  typedef struct packed {
    index_t    index;
    word_sel_t word_sel;
    word_t     data;
    tag_t      tag;
  } fill_wr_t;

  typedef struct packed {
    tlb_idx_t entry;
    logic     valid;
    vpn_t     vpn;
    ppn_t     ppn;
  } tlb_wr_t;

  typedef enum logic [2:0] {
    idle     = 3'b000,
    lookup   = 3'b001,
    bus_wait = 3'b010,
    fill     = 3'b011,
    respond  = 3'b100
  } ctrl_state_e;

endpackage

`default_nettype wire
